// ==== source/fpu_format_pkg.sv ====
////////////////////
// binary32 format package
// field widths, bias, value types and the classified operand
////////////////////

`default_nettype none

package fpu_format_pkg;

  localparam int WORD_W = 32;          // one binary32 word
  localparam int EXP_W  = 8;           // biased exponent field
  localparam int FRAC_W = 23;          // stored fraction field
  localparam int MANT_W = FRAC_W + 1;  // fraction plus hidden bit

  localparam int EXP_BIAS    = 127;
  localparam int EXP_MAX     = 255;           // inf / nan exponent
  localparam int I2F_EXP_TOP = EXP_BIAS + 31; // 2**31, leading one at bit 31

  typedef logic [WORD_W-1:0] float_t;  // raw float word
  typedef logic [EXP_W-1:0]  exp_t;    // biased exponent
  typedef logic [FRAC_W-1:0] frac_t;   // fraction w/o hidden bit
  typedef logic [MANT_W-1:0] mant_t;   // significand w/ hidden bit
  typedef logic [WORD_W-1:0] int_t;    // signed integer operand

  // operand split into fields plus its class
  typedef struct packed {
    logic  sign;
    exp_t  exp;
    frac_t frac;
    logic  is_zero;    // +0 or -0
    logic  is_denorm;  // exp 0, fraction nonzero
    logic  is_inf;
    logic  is_snan;
    logic  is_qnan;
  } operand_t;

endpackage

`default_nettype wire

// ==== source/fpu_ctrl_pkg.sv ====
////////////////////
// FPU control package
// opcodes, rounding modes, exception flags, i2f stage payload
////////////////////

`default_nettype none

package fpu_ctrl_pkg;

  typedef enum logic [2:0] {
    OP_I2F    = 3'd0,  // int32 to float
    OP_CMP_EQ = 3'd1,
    OP_CMP_NE = 3'd2,
    OP_CMP_GT = 3'd3,
    OP_CMP_GE = 3'd4,
    OP_CMP_LT = 3'd5,
    OP_CMP_LE = 3'd6
  } fpu_op_e;

  // OR1K FPCSR rounding mode order
  typedef enum logic [1:0] {
    RND_NEAREST = 2'd0,  // nearest, ties to even
    RND_ZERO    = 2'd1,  // truncate
    RND_PINF    = 2'd2,  // toward +inf
    RND_NINF    = 2'd3   // toward -inf
  } rnd_mode_e;

  typedef struct packed {
    logic invalid;
    logic inexact;
  } fpu_flags_t;

  // normalized i2f item between prenorm and round stages
  typedef struct packed {
    logic                  valid;
    logic                  sign;
    logic                  zero;      // integer was 0
    fpu_format_pkg::exp_t  exp;
    fpu_format_pkg::mant_t mant;      // leading one at msb
    logic                  guard;     // first dropped bit
    logic                  sticky;    // or of the rest
    rnd_mode_e             rnd_mode;  // mode travels with the item
  } i2f_norm_t;

endpackage

`default_nettype wire

// ==== source/fpu_operand_unpack.sv ====
////////////////////
// operand unpack
// splits a binary32 word into fields and classifies it
////////////////////

`default_nettype none

module fpu_operand_unpack (
  input  wire fpu_format_pkg::float_t    op_i,
  output fpu_format_pkg::operand_t       unpacked_o
);

  fpu_format_pkg::exp_t  exp;
  fpu_format_pkg::frac_t frac;
  logic                  exp_ones;   // exp all ones
  logic                  exp_zero;   // exp all zeros
  logic                  frac_zero;

  assign exp  = op_i[30:23];
  assign frac = op_i[22:0];

  assign exp_ones  = (exp == fpu_format_pkg::EXP_MAX);
  assign exp_zero  = (exp == '0);
  assign frac_zero = (frac == '0);

  always_comb begin
    unpacked_o.sign      = op_i[31];
    unpacked_o.exp       = exp;
    unpacked_o.frac      = frac;
    unpacked_o.is_zero   = exp_zero & frac_zero;    // either sign
    unpacked_o.is_denorm = exp_zero & ~frac_zero;   // no hidden bit
    unpacked_o.is_inf    = exp_ones & frac_zero;
    // snan: quiet bit clear, payload nonzero
    unpacked_o.is_snan   = exp_ones & ~frac[22] & (|frac[21:0]);
    unpacked_o.is_qnan   = exp_ones & frac[22];     // quiet bit set
  end

endmodule

`default_nettype wire

// ==== source/fpu_compare.sv ====
////////////////////
// float compare
// registered EQ/NE/GT/GE/LT/LE with IEEE unordered handling
////////////////////

`default_nettype none

module fpu_compare (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            start_i,
  input  wire fpu_ctrl_pkg::fpu_op_e     op_i,
  input  wire fpu_format_pkg::operand_t  a_i,
  input  wire fpu_format_pkg::operand_t  b_i,
  output logic                           valid_o,
  output logic                           flag_o,
  output fpu_ctrl_pkg::fpu_flags_t       flags_o
);

  localparam int MAG_W = fpu_format_pkg::EXP_W + fpu_format_pkg::FRAC_W;

  logic [MAG_W-1:0] mag_a;      // exp:frac orders denormals too
  logic [MAG_W-1:0] mag_b;
  logic             any_nan;    // unordered pair
  logic             any_snan;
  logic             both_zero;
  logic             a_eq_b;
  logic             a_lt_b;
  logic             ordered_op; // GT/GE/LT/LE
  logic             cmp_res;

  assign mag_a = {a_i.exp, a_i.frac};
  assign mag_b = {b_i.exp, b_i.frac};

  assign any_snan  = a_i.is_snan | b_i.is_snan;
  assign any_nan   = any_snan | a_i.is_qnan | b_i.is_qnan;
  assign both_zero = a_i.is_zero & b_i.is_zero;   // +0 == -0

  ////////////////////
  // relation of a to b, valid only when ordered
  assign a_eq_b = both_zero | ((a_i.sign == b_i.sign) & (mag_a == mag_b));

  always_comb begin
    if (both_zero)
      a_lt_b = 1'b0;
    else if (a_i.sign != b_i.sign)
      a_lt_b = a_i.sign;             // negative side is smaller
    else if (a_i.sign)
      a_lt_b = (mag_a > mag_b);      // both negative, bigger mag is smaller
    else
      a_lt_b = (mag_a < mag_b);
  end

  ////////////////////
  // opcode select
  always_comb begin
    ordered_op = 1'b0;
    case (op_i)
      fpu_ctrl_pkg::OP_CMP_EQ: cmp_res = a_eq_b & ~any_nan;
      fpu_ctrl_pkg::OP_CMP_NE: cmp_res = ~a_eq_b | any_nan;  // true if unordered
      fpu_ctrl_pkg::OP_CMP_GT: begin
        cmp_res    = ~a_lt_b & ~a_eq_b & ~any_nan;
        ordered_op = 1'b1;
      end
      fpu_ctrl_pkg::OP_CMP_GE: begin
        cmp_res    = ~a_lt_b & ~any_nan;
        ordered_op = 1'b1;
      end
      fpu_ctrl_pkg::OP_CMP_LT: begin
        cmp_res    = a_lt_b & ~any_nan;
        ordered_op = 1'b1;
      end
      fpu_ctrl_pkg::OP_CMP_LE: begin
        cmp_res    = (a_lt_b | a_eq_b) & ~any_nan;
        ordered_op = 1'b1;
      end
      default: cmp_res = 1'b0;       // not a compare
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
      flag_o  <= 1'b0;
    end else begin
      valid_o <= start_i;            // one-cycle strobe
      if (start_i)
        flag_o <= cmp_res;           // held until next compare
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      flags_o.invalid <= any_snan | (any_nan & ordered_op);
      flags_o.inexact <= 1'b0;       // compare is always exact
    end
  end

endmodule

`default_nettype wire

// ==== source/fpu_i2f_prenorm.sv ====
////////////////////
// i2f prenormalize
// abs value, leading-zero count, shift to bit 31, registered
////////////////////

`default_nettype none

module fpu_i2f_prenorm (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           start_i,
  input  wire fpu_ctrl_pkg::rnd_mode_e  rnd_mode_i,
  input  wire fpu_format_pkg::int_t     int_i,
  output fpu_ctrl_pkg::i2f_norm_t       norm_o
);

  // leading zeros of a 32-bit word, 32 for zero
  function automatic logic [5:0] lead_zeros(input logic [31:0] v);
    logic [5:0] cnt;
    logic       found;
    cnt   = 6'd0;
    found = 1'b0;
    for (int i = 31; i >= 0; i--) begin
      if (v[i])
        found = 1'b1;
      else if (!found)
        cnt = cnt + 6'd1;
    end
    return cnt;
  endfunction

  logic        sign;
  logic [31:0] abs_val;   // -2**31 maps to 2**31 unsigned
  logic [5:0]  lz;
  logic [31:0] shifted;   // leading one at bit 31

  assign sign    = int_i[31];
  assign abs_val = sign ? (~int_i + 32'd1) : int_i;
  assign lz      = lead_zeros(abs_val);
  assign shifted = abs_val << lz;

  always_ff @(posedge clk) begin
    if (rst)
      norm_o.valid <= 1'b0;
    else
      norm_o.valid <= start_i;
  end

  // payload only, no reset
  always_ff @(posedge clk) begin
    if (start_i) begin
      norm_o.sign     <= sign;
      norm_o.zero     <= (abs_val == '0);
      norm_o.exp      <= 8'(fpu_format_pkg::I2F_EXP_TOP - int'(lz));
      norm_o.mant     <= shifted[31:8];     // top 24 bits
      norm_o.guard    <= shifted[7];
      norm_o.sticky   <= |shifted[6:0];     // anything below guard
      norm_o.rnd_mode <= rnd_mode_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/fpu_round_pack.sv ====
////////////////////
// i2f round and pack
// rounds the normalized mantissa, packs binary32, flags inexact
////////////////////

`default_nettype none

module fpu_round_pack (
  input  wire                           clk,
  input  wire                           rst,
  input  wire fpu_ctrl_pkg::i2f_norm_t  norm_i,
  output logic                          valid_o,
  output fpu_format_pkg::float_t        result_o,
  output fpu_ctrl_pkg::fpu_flags_t      flags_o
);

  localparam int MANT_W = fpu_format_pkg::MANT_W;

  logic                  lost;        // guard or sticky set
  logic                  round_up;
  logic [MANT_W:0]       mant_sum;    // one extra bit for carry
  logic                  carry;       // mantissa overflowed to 2.0
  fpu_format_pkg::exp_t  exp_rnd;
  fpu_format_pkg::frac_t frac_rnd;
  fpu_format_pkg::float_t packed_res;

  assign lost = norm_i.guard | norm_i.sticky;

  ////////////////////
  // round decision per mode
  always_comb begin
    case (norm_i.rnd_mode)
      fpu_ctrl_pkg::RND_NEAREST:
        round_up = norm_i.guard & (norm_i.sticky | norm_i.mant[0]);  // ties to even
      fpu_ctrl_pkg::RND_ZERO:
        round_up = 1'b0;
      fpu_ctrl_pkg::RND_PINF:
        round_up = lost & ~norm_i.sign;
      fpu_ctrl_pkg::RND_NINF:
        round_up = lost & norm_i.sign;
      default:
        round_up = 1'b0;
    endcase
  end

  ////////////////////
  // increment and renormalize
  assign mant_sum = {1'b0, norm_i.mant} + (MANT_W + 1)'(round_up);
  assign carry    = mant_sum[MANT_W];
  assign exp_rnd  = norm_i.exp + fpu_format_pkg::exp_t'(carry);   // 1.11..1 -> 10.0

  // after carry the fraction is all zero
  assign frac_rnd = mant_sum[MANT_W-2:0];

  always_comb begin
    if (norm_i.zero)
      packed_res = '0;                  // int 0 gives +0
    else
      packed_res = {norm_i.sign, exp_rnd, frac_rnd};
  end

  always_ff @(posedge clk) begin
    if (rst)
      valid_o <= 1'b0;
    else
      valid_o <= norm_i.valid;          // one strobe per item
  end

  // result holds between valids
  always_ff @(posedge clk) begin
    if (norm_i.valid) begin
      result_o        <= packed_res;
      flags_o.invalid <= 1'b0;          // every int is representable
      flags_o.inexact <= lost;          // bits dropped below lsb
    end
  end

endmodule

`default_nettype wire

// ==== source/fpu_status_reg.sv ====
////////////////////
// FPU status register
// sticky invalid / inexact with clear
////////////////////

`default_nettype none

module fpu_status_reg (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            clear_i,
  input  wire                            arith_valid_i,
  input  wire fpu_ctrl_pkg::fpu_flags_t  arith_flags_i,
  input  wire                            cmp_valid_i,
  input  wire fpu_ctrl_pkg::fpu_flags_t  cmp_flags_i,
  output fpu_ctrl_pkg::fpu_flags_t       fpcsr_o
);

  fpu_ctrl_pkg::fpu_flags_t kept;    // old value after optional clear
  fpu_ctrl_pkg::fpu_flags_t arith_new;
  fpu_ctrl_pkg::fpu_flags_t cmp_new;

  assign kept      = clear_i       ? '0 : fpcsr_o;
  assign arith_new = arith_valid_i ? arith_flags_i : '0;  // only with a result
  assign cmp_new   = cmp_valid_i   ? cmp_flags_i   : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      fpcsr_o <= '0;
    end else begin
      // new flags win over a same-cycle clear
      fpcsr_o.invalid <= kept.invalid | arith_new.invalid | cmp_new.invalid;
      fpcsr_o.inexact <= kept.inexact | arith_new.inexact | cmp_new.inexact;
    end
  end

endmodule

`default_nettype wire

// ==== source/fpu_top.sv ====
////////////////////
// FPU top
// compare and int-to-float units with shared status register
////////////////////

`default_nettype none

module fpu_top (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            start_i,
  input  wire fpu_ctrl_pkg::fpu_op_e     op_i,
  input  wire fpu_ctrl_pkg::rnd_mode_e   rnd_mode_i,
  input  wire fpu_format_pkg::float_t    opa_i,
  input  wire fpu_format_pkg::float_t    opb_i,
  input  wire                            flags_clear_i,
  output fpu_format_pkg::float_t         result_o,
  output logic                           arith_valid_o,
  output logic                           cmp_flag_o,
  output logic                           cmp_valid_o,
  output fpu_ctrl_pkg::fpu_flags_t       fpcsr_o
);

  fpu_format_pkg::operand_t  opa_unp;      // classified a
  fpu_format_pkg::operand_t  opb_unp;      // classified b
  logic                      cmp_start;
  logic                      i2f_start;
  fpu_ctrl_pkg::i2f_norm_t   i2f_norm;     // prenorm -> round
  fpu_ctrl_pkg::fpu_flags_t  arith_flags;
  fpu_ctrl_pkg::fpu_flags_t  cmp_flags;

  ////////////////////
  // strobe split
  assign i2f_start = start_i & (op_i == fpu_ctrl_pkg::OP_I2F);
  assign cmp_start = start_i & (op_i != fpu_ctrl_pkg::OP_I2F);  // all others compare

  fpu_operand_unpack unpack_a_inst (.op_i(opa_i), .unpacked_o(opa_unp));
  fpu_operand_unpack unpack_b_inst (.op_i(opb_i), .unpacked_o(opb_unp));

  fpu_compare compare_inst (
    .clk     (clk),
    .rst     (rst),
    .start_i (cmp_start),
    .op_i    (op_i),
    .a_i     (opa_unp),
    .b_i     (opb_unp),
    .valid_o (cmp_valid_o),
    .flag_o  (cmp_flag_o),
    .flags_o (cmp_flags)
  );

  ////////////////////
  // int to float, two stages
  fpu_i2f_prenorm i2f_prenorm_inst (
    .clk        (clk),
    .rst        (rst),
    .start_i    (i2f_start),
    .rnd_mode_i (rnd_mode_i),
    .int_i      (opa_i),         // opa holds the integer
    .norm_o     (i2f_norm)
  );

  fpu_round_pack round_pack_inst (
    .clk      (clk),
    .rst      (rst),
    .norm_i   (i2f_norm),
    .valid_o  (arith_valid_o),
    .result_o (result_o),
    .flags_o  (arith_flags)
  );

  fpu_status_reg status_reg_inst (
    .clk           (clk),
    .rst           (rst),
    .clear_i       (flags_clear_i),
    .arith_valid_i (arith_valid_o),
    .arith_flags_i (arith_flags),
    .cmp_valid_i   (cmp_valid_o),
    .cmp_flags_i   (cmp_flags),
    .fpcsr_o       (fpcsr_o)
  );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
////////////////////
// testbench clock, 20 unit period
////////////////////

`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  localparam int HALF_PERIOD = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;  // free running
  end

endmodule

`default_nettype wire

// ==== verification/fpu_top_tb.sv ====
////////////////////
// FPU testbench
// random compares and int-to-float conversions against a model
////////////////////

`default_nettype none

module fpu_top_tb;

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 2;
  localparam int NUM_CYCLES    = 600;   // stimulus cycles, some idle
  localparam int SEED          = 87042;
  localparam int WATCHDOG_TIME = (NUM_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD;

  typedef struct packed {
    logic [31:0] due;      // cycle count when the result shows
    logic [31:0] value;    // float word, or compare flag in bit 0
    logic        invalid;
    logic        inexact;
  } exp_item_t;

  logic                      clk;
  logic                      rst;
  logic                      start;
  fpu_ctrl_pkg::fpu_op_e     op;
  fpu_ctrl_pkg::rnd_mode_e   rnd_mode;
  fpu_format_pkg::float_t    opa;
  fpu_format_pkg::float_t    opb;
  logic                      flags_clear;
  fpu_format_pkg::float_t    result;
  logic                      arith_valid;
  logic                      cmp_flag;
  logic                      cmp_valid;
  fpu_ctrl_pkg::fpu_flags_t  fpcsr;

  exp_item_t                 cmp_q[$];       // compares in flight
  exp_item_t                 i2f_q[$];       // conversions in flight
  fpu_ctrl_pkg::fpu_flags_t  fpcsr_model;    // expected sticky flags
  logic [31:0]               last_result;
  logic                      have_result;
  logic                      last_cmp_flag;
  int                        cyc;
  int                        checks;
  int                        value_errs;
  int                        proto_errs;

  tb_clock_gen clock_gen_inst (.clk_o(clk));

  fpu_top fpu_top_inst (
    .clk           (clk),
    .rst           (rst),
    .start_i       (start),
    .op_i          (op),
    .rnd_mode_i    (rnd_mode),
    .opa_i         (opa),
    .opb_i         (opb),
    .flags_clear_i (flags_clear),
    .result_o      (result),
    .arith_valid_o (arith_valid),
    .cmp_flag_o    (cmp_flag),
    .cmp_valid_o   (cmp_valid),
    .fpcsr_o       (fpcsr)
  );

  always @(posedge clk) cyc <= cyc + 1;  // edge count

  ////////////////////
  // reference model
  function automatic logic is_nan(input logic [31:0] f);
    return (f[30:23] == 8'hff) && (f[22:0] != 23'd0);
  endfunction

  function automatic logic is_snan(input logic [31:0] f);
    return is_nan(f) && !f[22];  // quiet bit clear
  endfunction

  // signed key, same order as the float values, -0 maps onto +0
  function automatic longint order_key(input logic [31:0] f);
    longint mag;
    mag = longint'(f[30:0]);
    return f[31] ? -mag : mag;
  endfunction

  task automatic model_cmp(input fpu_ctrl_pkg::fpu_op_e o, input logic [31:0] a,
                           input logic [31:0] b, output logic flag, output logic inv);
    logic   unord;
    longint ka;
    longint kb;
    unord = is_nan(a) || is_nan(b);
    ka    = order_key(a);
    kb    = order_key(b);
    case (o)
      fpu_ctrl_pkg::OP_CMP_EQ: flag = !unord && (ka == kb);
      fpu_ctrl_pkg::OP_CMP_NE: flag = unord || (ka != kb);
      fpu_ctrl_pkg::OP_CMP_GT: flag = !unord && (ka > kb);
      fpu_ctrl_pkg::OP_CMP_GE: flag = !unord && (ka >= kb);
      fpu_ctrl_pkg::OP_CMP_LT: flag = !unord && (ka < kb);
      fpu_ctrl_pkg::OP_CMP_LE: flag = !unord && (ka <= kb);
      default:                 flag = 1'b0;
    endcase
    inv = is_snan(a) || is_snan(b) ||
          (unord && (o != fpu_ctrl_pkg::OP_CMP_EQ) && (o != fpu_ctrl_pkg::OP_CMP_NE));
  endtask

  // exact integer arithmetic on the dropped remainder
  task automatic model_i2f(input logic [31:0] ival, input fpu_ctrl_pkg::rnd_mode_e m,
                           output logic [31:0] res, output logic inx);
    longint mag;
    longint q;
    longint rem;
    longint half;
    int     msb;
    logic   sign;
    logic   up;
    sign = ival[31];
    mag  = sign ? -longint'($signed(ival)) : longint'(ival);
    res  = 32'd0;                                  // int 0 gives +0
    rem  = 0;
    up   = 1'b0;
    if (mag != 0) begin
      msb = 0;
      for (int i = 0; i < 33; i++) begin
        if (mag[i])
          msb = i;
      end
      if (msb <= 23) begin
        q = mag << (23 - msb);                     // fits, exact
      end else begin
        q    = mag >> (msb - 23);
        rem  = mag - (q << (msb - 23));
        half = longint'(1) << (msb - 24);
        case (m)
          fpu_ctrl_pkg::RND_NEAREST: up = (rem > half) || ((rem == half) && q[0]);
          fpu_ctrl_pkg::RND_ZERO:    up = 1'b0;
          fpu_ctrl_pkg::RND_PINF:    up = (rem != 0) && !sign;
          default:                   up = (rem != 0) && sign;
        endcase
        q = q + longint'(up);
        if (q == (longint'(1) << 24)) begin       // rounded past 2.0
          q   = q >> 1;
          msb = msb + 1;
        end
      end
      res = {sign, 8'(127 + msb), q[22:0]};
    end
    inx = (rem != 0);
  endtask

  ////////////////////
  // stimulus picks
  function automatic logic [31:0] pick_int();
    case ($urandom_range(0, 9))
      0: return 32'h0000_0000;
      1: return 32'h8000_0000;                     // most negative
      2: return 32'h7fff_ffff;
      3: return 32'h0100_0001;                     // 2**24 + 1, tie to even
      4: return 32'h0100_0003;                     // tie, rounds up
      5: return 32'hfeff_ffff;                     // -(2**24 + 1)
      6: return $urandom() & 32'h00ff_ffff;        // exact range
      7: return 32'd0 - ($urandom() & 32'h00ff_ffff);
      default: return $urandom();
    endcase
  endfunction

  function automatic logic [31:0] pick_float();
    case ($urandom_range(0, 15))
      0: return 32'h0000_0000;                     // +0
      1: return 32'h8000_0000;                     // -0
      2: return 32'h7f80_0000;                     // +inf
      3: return 32'hff80_0000;                     // -inf
      4: return 32'h7fc0_0000;                     // quiet nan
      5: return 32'hffc0_1234;
      6: return 32'h7f80_0001;                     // signaling nan
      7: return 32'hffa0_0000;
      8: return 32'h0000_0001;                     // smallest denormal
      9: return 32'h807f_ffff;
      10, 11: return {1'($urandom_range(0, 1)), 8'h00, 23'($urandom())};
      default: return $urandom();
    endcase
  endfunction

  function automatic logic [31:0] pick_partner(input logic [31:0] a);
    case ($urandom_range(0, 7))
      0, 1: return a;                              // equal pair
      2: return {~a[31], a[30:0]};                 // sign flipped
      3: return a + 32'd1;                         // next code up
      default: return pick_float();
    endcase
  endfunction

  ////////////////////
  // checks
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp_v);
    checks++;
    assert (got === exp_v) else begin
      value_errs++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp_v);
    end
  endtask

  task automatic expect_true(input logic ok, input string what);
    checks++;
    assert (ok === 1'b1) else begin
      proto_errs++;
      $display("ERROR t=%0t %s", $time, what);
    end
  endtask

  task automatic verify_reset();
    compare_value("arith_valid_o", {31'b0, arith_valid}, 32'd0);
    compare_value("cmp_valid_o", {31'b0, cmp_valid}, 32'd0);
    compare_value("cmp_flag_o", {31'b0, cmp_flag}, 32'd0);
    compare_value("fpcsr_o", {30'b0, fpcsr}, 32'd0);
  endtask

  // runs at the falling edge, outputs are stable there
  task automatic score_cycle();
    exp_item_t                item;
    fpu_ctrl_pkg::fpu_flags_t nxt;
    compare_value("fpcsr_o", {30'b0, fpcsr}, {30'b0, fpcsr_model});
    nxt = flags_clear ? '0 : fpcsr_model;          // clear taken at next edge
    if (cmp_q.size() != 0 && cmp_q[0].due == cyc) begin
      item = cmp_q.pop_front();
      expect_true(cmp_valid, "cmp_valid_o missing for a due compare");
      compare_value("cmp_flag_o", {31'b0, cmp_flag}, item.value);
      last_cmp_flag = item.value[0];
      nxt.invalid   = nxt.invalid | item.invalid;
    end else begin
      expect_true(!cmp_valid, "cmp_valid_o raised with no compare due");
      compare_value("cmp_flag_o held", {31'b0, cmp_flag}, {31'b0, last_cmp_flag});
    end
    if (i2f_q.size() != 0 && i2f_q[0].due == cyc) begin
      item = i2f_q.pop_front();
      expect_true(arith_valid, "arith_valid_o missing for a due conversion");
      compare_value("result_o", result, item.value);
      last_result = item.value;
      have_result = 1'b1;
      nxt.inexact = nxt.inexact | item.inexact;
      nxt.invalid = nxt.invalid | item.invalid;
    end else begin
      expect_true(!arith_valid, "arith_valid_o raised with no conversion due");
      if (have_result)
        compare_value("result_o held", result, last_result);
    end
    fpcsr_model = nxt;
  endtask

  always @(negedge clk) begin
    if (!rst)
      score_cycle();
  end

  ////////////////////
  // stimulus, called right after a rising edge
  task automatic issue_random();
    exp_item_t               item;
    fpu_ctrl_pkg::fpu_op_e   o;
    fpu_ctrl_pkg::rnd_mode_e m;
    logic [31:0]             a;
    logic [31:0]             b;
    logic [31:0]             res;
    logic                    flag;
    logic                    inv;
    logic                    inx;
    flags_clear <= ($urandom_range(0, 15) == 0);
    if ($urandom_range(0, 7) == 0) begin
      start <= 1'b0;                               // idle cycle
    end else begin
      m = fpu_ctrl_pkg::rnd_mode_e'($urandom_range(0, 3));
      if ($urandom_range(0, 9) < 4) begin
        o = fpu_ctrl_pkg::OP_I2F;
        a = pick_int();
        b = $urandom();                            // ignored by the DUT
        model_i2f(a, m, res, inx);
        item.due     = 32'(cyc + 3);               // sampled next edge, two stages
        item.value   = res;
        item.invalid = 1'b0;
        item.inexact = inx;
        i2f_q.push_back(item);
      end else begin
        o = fpu_ctrl_pkg::fpu_op_e'($urandom_range(1, 6));
        a = pick_float();
        b = pick_partner(a);
        model_cmp(o, a, b, flag, inv);
        item.due     = 32'(cyc + 2);
        item.value   = {31'b0, flag};
        item.invalid = inv;
        item.inexact = 1'b0;
        cmp_q.push_back(item);
      end
      start    <= 1'b1;
      op       <= o;
      rnd_mode <= m;
      opa      <= a;
      opb      <= b;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst           = 1'b1;
    start         = 1'b0;
    op            = fpu_ctrl_pkg::OP_I2F;
    rnd_mode      = fpu_ctrl_pkg::RND_NEAREST;
    opa           = '0;
    opb           = '0;
    flags_clear   = 1'b0;
    fpcsr_model   = '0;
    last_result   = '0;
    have_result   = 1'b0;
    last_cmp_flag = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    verify_reset();
    for (int n = 0; n < NUM_CYCLES; n++) begin
      @(posedge clk);
      issue_random();
    end
    @(posedge clk);
    start       <= 1'b0;
    flags_clear <= 1'b0;
    while (cmp_q.size() != 0 || i2f_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);                     // last flags land and get scored
    $display("checks %0d, value errors %0d, protocol errors %0d",
             checks, value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired before the run finished");
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fpu_top.f ====
source/fpu_format_pkg.sv
source/fpu_ctrl_pkg.sv
source/fpu_operand_unpack.sv
source/fpu_compare.sv
source/fpu_i2f_prenorm.sv
source/fpu_round_pack.sv
source/fpu_status_reg.sv
source/fpu_top.sv
verification/tb_clock_gen.sv
verification/fpu_top_tb.sv

// ==== Makefile ====
# Verilator build and run of the FPU testbench

TOP = fpu_top_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f fpu_top.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "test FAILED, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
